// ==== l2_cache_ctrl.sv ====
module l2_cache_ctrl (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  // request / response
  input  logic                                           req_valid_i,
  output logic                                           req_ready_o,
  input  l2_cache_pkg::cpu_req_t                         req_i,
  output logic                                           rsp_valid_o,
  input  logic                                           rsp_ready_i,
  output l2_cache_pkg::cpu_rsp_t                         rsp_o,
  // memory side
  output logic                                           ar_valid_o,
  input  logic                                           ar_ready_i,
  output l2_cache_pkg::mem_addr_t                        ar_o,
  output logic                                           aw_valid_o,
  input  logic                                           aw_ready_i,
  output l2_cache_pkg::mem_addr_t                        aw_o,
  output logic                                           w_valid_o,
  input  logic                                           w_ready_i,
  output l2_cache_pkg::mem_wdata_t                       w_o,
  input  logic                                           r_valid_i,
  output logic                                           r_ready_o,
  input  l2_cache_pkg::mem_rdata_t                       r_i,
  input  logic                                           b_valid_i,
  output logic                                           b_ready_o,
  // tag array
  output logic                                           tag_req_o,
  output logic                                           tag_we_o,
  output l2_cache_pkg::set_idx_t                         tag_set_o,
  output l2_cache_pkg::way_idx_t                         tag_way_o,
  output l2_cache_pkg::tag_t                             tag_wr_o,
  output logic                                           tag_dirty_o,
  input  l2_cache_pkg::tag_lookup_t                      lookup_i,
  // data array
  output logic                                           data_req_o,
  output logic                                           data_we_o,
  output l2_cache_pkg::set_idx_t                         data_set_o,
  output l2_cache_pkg::way_idx_t                         data_way_o,
  output l2_cache_pkg::beat_idx_t                        data_beat_o,
  output l2_cache_pkg::data_t                            data_wr_o,
  input  l2_cache_pkg::data_t [l2_cache_pkg::way_num-1:0] data_rd_i,
  // replacement
  output logic                                           lru_update_o,
  output l2_cache_pkg::set_idx_t                         lru_set_o,
  output l2_cache_pkg::way_idx_t                         lru_way_o,
  input  l2_cache_pkg::way_idx_t                         victim_way_i
);
  import l2_cache_pkg::*;

  ctrl_state_e state_q, state_d;
  cpu_req_t    req_q;
  tag_lookup_t lookup_q;
  beat_idx_t   cnt_q, cnt_d;
  tag_t        req_tag;
  set_idx_t    req_set;
  beat_idx_t   req_beat;
  logic        victim_dirty;

  // address fields of the held request
  assign req_tag  = req_q.addr[offset_w+set_w +: tag_w];
  assign req_set  = req_q.addr[offset_w +: set_w];
  assign req_beat = req_q.addr[offset_w-1 -: beat_w];
  // write back needed only for a valid dirty victim
  assign victim_dirty = lookup_q.valid[victim_way_i] & lookup_q.dirty[victim_way_i];

  // ====================
  // channel payloads
  // ====================
  assign rsp_o.op     = (req_q.op == op_get) ? op_ack_data : op_ack;
  assign rsp_o.source = req_q.source;
  assign rsp_o.data   = data_rd_i[lookup_q.hit_way];
  // victim line goes back under its old tag
  assign aw_o.addr    = {lookup_q.tags[victim_way_i], req_set, {offset_w{1'b0}}};
  assign ar_o.addr    = {req_tag, req_set, {offset_w{1'b0}}};
  assign w_o.data     = data_rd_i[victim_way_i];
  assign w_o.last     = (cnt_q == beat_idx_t'(beat_num - 1));

  // array addressing, always the request set
  assign tag_set_o   = req_set;
  assign tag_wr_o    = req_tag;
  assign tag_way_o   = (state_q == write_rsp) ? lookup_q.hit_way : victim_way_i;
  // dirty on write hit, clean on refill
  assign tag_dirty_o = (state_q == write_rsp);
  assign data_set_o  = req_set;
  assign data_way_o  = (state_q == refill) ? victim_way_i : lookup_i.hit_way;
  assign data_wr_o   = (state_q == refill) ? r_i.data : req_q.data;
  assign lru_set_o   = req_set;
  assign lru_way_o   = (state_q == refill) ? victim_way_i : lookup_i.hit_way;

  // ====================
  // FSM
  // ====================
  always_comb begin
    state_d      = state_q;
    cnt_d        = cnt_q;
    req_ready_o  = 1'b0;
    rsp_valid_o  = 1'b0;
    ar_valid_o   = 1'b0;
    aw_valid_o   = 1'b0;
    w_valid_o    = 1'b0;
    r_ready_o    = 1'b0;
    b_ready_o    = 1'b0;
    tag_req_o    = 1'b0;
    tag_we_o     = 1'b0;
    data_req_o   = 1'b0;
    data_we_o    = 1'b0;
    data_beat_o  = req_beat;
    lru_update_o = 1'b0;
    case (state_q)
      idle: begin
        req_ready_o = 1'b1;
        if (req_valid_i) begin
          state_d = read_tag;
        end
      end
      read_tag: begin
        tag_req_o = 1'b1;
        state_d   = is_hit;
      end
      // lookup is valid here
      is_hit: begin
        if (|lookup_i.hit) begin
          lru_update_o = 1'b1;
          data_req_o   = 1'b1;
          if (req_q.op == op_put) begin
            // commit the beat now
            data_we_o = 1'b1;
            state_d   = write_rsp;
          end else begin
            state_d = read_data;
          end
        end else begin
          cnt_d   = '0;
          state_d = is_dirty;
        end
      end
      // ack while the line is marked dirty
      write_rsp: begin
        tag_req_o   = 1'b1;
        tag_we_o    = 1'b1;
        rsp_valid_o = 1'b1;
        if (rsp_ready_i) begin
          state_d = idle;
        end
      end
      read_data: begin
        rsp_valid_o = 1'b1;
        if (rsp_ready_i) begin
          state_d = idle;
        end
      end
      is_dirty: begin
        state_d = victim_dirty ? wb_req : refill_req;
      end
      // beat 0 of the victim is read while aw waits
      wb_req: begin
        aw_valid_o  = 1'b1;
        data_req_o  = 1'b1;
        data_beat_o = cnt_d;
        if (aw_ready_i) begin
          state_d = wb_data;
        end
      end
      wb_data: begin
        w_valid_o = 1'b1;
        if (w_ready_i) begin
          cnt_d = cnt_q + beat_idx_t'(1);
          if (w_o.last) begin
            state_d = wait_b;
          end
        end
        // prefetch the next beat on a handshake
        data_req_o  = 1'b1;
        data_beat_o = cnt_d;
      end
      wait_b: begin
        b_ready_o = 1'b1;
        if (b_valid_i) begin
          state_d = refill_req;
        end
      end
      refill_req: begin
        ar_valid_o = 1'b1;
        cnt_d      = '0;
        if (ar_ready_i) begin
          state_d = refill;
        end
      end
      // beats land in order in the victim way
      refill: begin
        r_ready_o   = 1'b1;
        data_beat_o = cnt_q;
        if (r_valid_i) begin
          data_req_o = 1'b1;
          data_we_o  = 1'b1;
          cnt_d      = cnt_q + beat_idx_t'(1);
          if (r_i.last) begin
            // tag valid and clean with the last beat
            tag_req_o    = 1'b1;
            tag_we_o     = 1'b1;
            lru_update_o = 1'b1;
            state_d      = replay;
          end
        end
      end
      // re-read so the request completes as a hit
      replay: begin
        tag_req_o = 1'b1;
        state_d   = is_hit;
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  // ====================
  // registers
  // ====================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // request and lookup payload
  always_ff @(posedge clk_i) begin
    if (state_q == idle && req_valid_i) begin
      req_q <= req_i;
    end
    if (state_q == is_hit) begin
      lookup_q <= lookup_i;
    end
  end

endmodule

// ==== l2_cache_pkg.sv ====
package l2_cache_pkg;

  // ====================
  // geometry
  // ====================
  localparam int way_num  = 4;
  localparam int set_num  = 16;
  localparam int beat_num = 4;
  localparam int way_w    = 2;
  localparam int set_w    = 4;
  localparam int beat_w   = 2;
  // 32-byte line
  localparam int offset_w = 5;
  // addr = {tag, set, offset}
  localparam int tag_w    = 23;

  // widths with a meaning
  typedef logic [31:0]         addr_t;
  typedef logic [63:0]         data_t;
  typedef logic [tag_w-1:0]    tag_t;
  typedef logic [set_w-1:0]    set_idx_t;
  typedef logic [way_w-1:0]    way_idx_t;
  typedef logic [beat_w-1:0]   beat_idx_t;
  typedef logic [way_num-1:0]  way_vec_t;
  typedef logic [3:0]          source_t;

  // request / response opcodes
  typedef enum logic {op_get, op_put} req_op_e;
  typedef enum logic {op_ack, op_ack_data} rsp_op_e;

  // controller states
  typedef enum logic [3:0] {
    idle, read_tag, is_hit, write_data, write_rsp, read_data, is_dirty,
    wb_req, wb_data, wait_b, refill_req, refill, replay
  } ctrl_state_e;

  // ====================
  // channel payloads
  // ====================
  typedef struct packed {
    req_op_e op;
    addr_t   addr;
    source_t source;
    data_t   data;
  } cpu_req_t;

  typedef struct packed {
    rsp_op_e op;
    source_t source;
    data_t   data;
  } cpu_rsp_t;

  // line aligned burst address
  typedef struct packed {
    addr_t addr;
  } mem_addr_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } mem_wdata_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } mem_rdata_t;

  // one registered set read, compared against the request tag
  typedef struct packed {
    way_vec_t             hit;
    way_idx_t             hit_way;
    way_vec_t             valid;
    way_vec_t             dirty;
    tag_t [way_num-1:0]   tags;
  } tag_lookup_t;

endpackage

// ==== l2_cache_top.f ====
l2_cache_pkg.sv
l2_tag_array.sv
l2_data_array.sv
l2_victim_select.sv
l2_cache_ctrl.sv
l2_cache_top.sv
tb_clk_gen.sv
tb_mem_model.sv
tb_l2_cache.sv

// ==== l2_cache_top.sv ====
module l2_cache_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // request / response
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  l2_cache_pkg::cpu_req_t   req_i,
  output logic                     rsp_valid_o,
  input  logic                     rsp_ready_i,
  output l2_cache_pkg::cpu_rsp_t   rsp_o,
  // memory side
  output logic                     ar_valid_o,
  input  logic                     ar_ready_i,
  output l2_cache_pkg::mem_addr_t  ar_o,
  output logic                     aw_valid_o,
  input  logic                     aw_ready_i,
  output l2_cache_pkg::mem_addr_t  aw_o,
  output logic                     w_valid_o,
  input  logic                     w_ready_i,
  output l2_cache_pkg::mem_wdata_t w_o,
  input  logic                     r_valid_i,
  output logic                     r_ready_o,
  input  l2_cache_pkg::mem_rdata_t r_i,
  input  logic                     b_valid_i,
  output logic                     b_ready_o
);
  import l2_cache_pkg::*;

  // tag array link
  logic        tag_req, tag_we, tag_dirty;
  set_idx_t    tag_set;
  way_idx_t    tag_way;
  tag_t        tag_wr;
  tag_lookup_t lookup;
  // data array link
  logic                  data_req, data_we;
  set_idx_t              data_set;
  way_idx_t              data_way;
  beat_idx_t             data_beat;
  data_t                 data_wr;
  data_t [way_num-1:0]   data_rd;
  // replacement link
  logic     lru_update;
  set_idx_t lru_set;
  way_idx_t lru_way, victim_way;

  l2_cache_ctrl i_ctrl (
    .clk_i, .rst_n_i,
    .req_valid_i, .req_ready_o, .req_i,
    .rsp_valid_o, .rsp_ready_i, .rsp_o,
    .ar_valid_o, .ar_ready_i, .ar_o,
    .aw_valid_o, .aw_ready_i, .aw_o,
    .w_valid_o, .w_ready_i, .w_o,
    .r_valid_i, .r_ready_o, .r_i,
    .b_valid_i, .b_ready_o,
    .tag_req_o(tag_req), .tag_we_o(tag_we), .tag_set_o(tag_set),
    .tag_way_o(tag_way), .tag_wr_o(tag_wr), .tag_dirty_o(tag_dirty),
    .lookup_i(lookup),
    .data_req_o(data_req), .data_we_o(data_we), .data_set_o(data_set),
    .data_way_o(data_way), .data_beat_o(data_beat), .data_wr_o(data_wr),
    .data_rd_i(data_rd),
    .lru_update_o(lru_update), .lru_set_o(lru_set), .lru_way_o(lru_way),
    .victim_way_i(victim_way)
  );

  l2_tag_array i_tag_array (
    .clk_i, .rst_n_i,
    .req_i(tag_req), .we_i(tag_we), .set_i(tag_set), .way_i(tag_way),
    .tag_i(tag_wr), .dirty_i(tag_dirty), .lookup_o(lookup)
  );

  l2_data_array i_data_array (
    .clk_i,
    .req_i(data_req), .we_i(data_we), .set_i(data_set), .way_i(data_way),
    .beat_i(data_beat), .wdata_i(data_wr), .rdata_o(data_rd)
  );

  // victim looks at the valid bits of the last set read
  l2_victim_select i_victim_select (
    .clk_i, .rst_n_i,
    .update_i(lru_update), .set_i(lru_set), .way_i(lru_way),
    .valid_i(lookup.valid), .lookup_set_i(lru_set), .victim_way_o(victim_way)
  );

endmodule

// ==== l2_data_array.sv ====
module l2_data_array (
  input  logic                                           clk_i,
  input  logic                                           req_i,
  input  logic                                           we_i,
  input  l2_cache_pkg::set_idx_t                         set_i,
  input  l2_cache_pkg::way_idx_t                         way_i,
  input  l2_cache_pkg::beat_idx_t                        beat_i,
  input  l2_cache_pkg::data_t                            wdata_i,
  output l2_cache_pkg::data_t [l2_cache_pkg::way_num-1:0] rdata_o
);
  import l2_cache_pkg::*;

  // line storage, one beat per entry
  data_t mem_q [set_num][beat_num][way_num];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // single beat into a single way
        mem_q[set_i][beat_i][way_i] <= wdata_i;
      end else begin
        // same beat of every way
        // held until the next read
        for (int w = 0; w < way_num; w++) begin
          rdata_o[w] <= mem_q[set_i][beat_i][w];
        end
      end
    end
  end

endmodule

// ==== l2_tag_array.sv ====
module l2_tag_array (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  l2_cache_pkg::set_idx_t    set_i,
  input  l2_cache_pkg::way_idx_t    way_i,
  input  l2_cache_pkg::tag_t        tag_i,
  input  logic                      dirty_i,
  output l2_cache_pkg::tag_lookup_t lookup_o
);
  import l2_cache_pkg::*;

  // storage
  tag_t     tag_mem_q [set_num][way_num];
  way_vec_t valid_q [set_num];
  way_vec_t dirty_q [set_num];
  // registered read of one set
  tag_t [way_num-1:0] rd_tag_q;
  way_vec_t           rd_valid_q;
  way_vec_t           rd_dirty_q;
  tag_t               cmp_tag_q;

  // tag write, one way
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      tag_mem_q[set_i][way_i] <= tag_i;
    end
  end

  // valid and dirty bits, cleared by reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < set_num; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
      end
      rd_valid_q <= '0;
      rd_dirty_q <= '0;
    end else if (req_i) begin
      if (we_i) begin
        // any write leaves the line valid
        valid_q[set_i][way_i] <= 1'b1;
        dirty_q[set_i][way_i] <= dirty_i;
      end else begin
        rd_valid_q <= valid_q[set_i];
        rd_dirty_q <= dirty_q[set_i];
      end
    end
  end

  // read side tags plus the tag to compare with
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      cmp_tag_q <= tag_i;
      for (int w = 0; w < way_num; w++) begin
        rd_tag_q[w] <= tag_mem_q[set_i][w];
      end
    end
  end

  // ====================
  // hit detection
  // ====================
  always_comb begin
    lookup_o.hit_way = '0;
    for (int w = 0; w < way_num; w++) begin
      lookup_o.hit[w] = rd_valid_q[w] && (rd_tag_q[w] == cmp_tag_q);
      if (lookup_o.hit[w]) begin
        lookup_o.hit_way = way_idx_t'(w);
      end
    end
    lookup_o.valid = rd_valid_q;
    lookup_o.dirty = rd_dirty_q;
    lookup_o.tags  = rd_tag_q;
  end

endmodule

// ==== l2_victim_select.sv ====
module l2_victim_select (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   update_i,
  input  l2_cache_pkg::set_idx_t set_i,
  input  l2_cache_pkg::way_idx_t way_i,
  input  l2_cache_pkg::way_vec_t valid_i,
  input  l2_cache_pkg::set_idx_t lookup_set_i,
  output l2_cache_pkg::way_idx_t victim_way_o
);
  import l2_cache_pkg::*;

  // bit 0 root, bit 1 pair of ways 0/1, bit 2 pair of ways 2/3
  logic [way_num-2:0] plru_q [set_num];
  logic [way_num-2:0] cur_bits;
  way_idx_t           inv_way;
  way_idx_t           plru_way;
  logic               any_inv;

  // ====================
  // tree update
  // ====================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int s = 0; s < set_num; s++) begin
        plru_q[s] <= '0;
      end
    end else if (update_i) begin
      // root points to the other pair
      plru_q[set_i][0] <= ~way_i[1];
      // pair bit points to the other way of the pair
      if (way_i[1]) begin
        plru_q[set_i][2] <= ~way_i[0];
      end else begin
        plru_q[set_i][1] <= ~way_i[0];
      end
    end
  end

  // ====================
  // victim choice
  // ====================
  always_comb begin
    cur_bits = plru_q[lookup_set_i];
    inv_way  = '0;
    any_inv  = 1'b0;
    // scan down so the lowest invalid way wins
    for (int w = way_num - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_way = way_idx_t'(w);
        any_inv = 1'b1;
      end
    end
    // walk the tree
    plru_way     = {cur_bits[0], cur_bits[0] ? cur_bits[2] : cur_bits[1]};
    victim_way_o = any_inv ? inv_way : plru_way;
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the L2 cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_l2_cache -f l2_cache_top.f
./obj_dir/Vtb_l2_cache | tee sim.log

if grep -qx "all tests passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== tb_clk_gen.sv ====
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  // reset held for 5 cycles, released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== tb_l2_cache.sv ====
module tb_l2_cache;
  timeunit 1ns;
  timeprecision 1ps;
  import l2_cache_pkg::*;

  localparam int reset_limit  = 20;
  localparam int accept_limit = 50;
  localparam int rsp_limit    = 1000;

  logic       clk;
  logic       rst_n;
  logic       req_valid;
  logic       req_ready;
  cpu_req_t   req;
  logic       rsp_valid;
  logic       rsp_ready;
  cpu_rsp_t   rsp;
  logic       ar_valid, ar_ready, aw_valid, aw_ready;
  logic       w_valid, w_ready, r_valid, r_ready, b_valid, b_ready;
  mem_addr_t  ar, aw;
  mem_wdata_t w;
  mem_rdata_t r;
  int         ar_count, aw_count;

  // reference line store holding only written beats
  data_t      ref_mem [addr_t];
  // seen on the memory channels
  addr_t      last_ar = '0;
  addr_t      last_aw = '0;
  time        ar_time = 0;
  time        aw_time = 0;
  mem_wdata_t w_beats [$];
  // bookkeeping
  int         errors = 0;
  int         errors_at_start = 0;
  int         tests_run = 0;
  int         tests_failed = 0;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  tb_mem_model i_mem_model (
    .clk_i(clk), .rst_n_i(rst_n),
    .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_i(ar),
    .r_valid_o(r_valid), .r_ready_i(r_ready), .r_o(r),
    .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_i(aw),
    .w_valid_i(w_valid), .w_ready_o(w_ready), .w_i(w),
    .b_valid_o(b_valid), .b_ready_i(b_ready),
    .ar_cnt_o(ar_count), .aw_cnt_o(aw_count)
  );

  l2_cache_top i_l2_cache_top (
    .clk_i(clk), .rst_n_i(rst_n),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_i(req),
    .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready), .rsp_o(rsp),
    .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_o(ar),
    .aw_valid_o(aw_valid), .aw_ready_i(aw_ready), .aw_o(aw),
    .w_valid_o(w_valid), .w_ready_i(w_ready), .w_o(w),
    .r_valid_i(r_valid), .r_ready_o(r_ready), .r_i(r),
    .b_valid_i(b_valid), .b_ready_o(b_ready)
  );

  // handshakes sampled mid-cycle complete on the next edge
  always @(negedge clk) begin
    if (ar_valid && ar_ready) begin
      last_ar <= ar.addr;
      ar_time <= $time;
    end
    if (aw_valid && aw_ready) begin
      last_aw <= aw.addr;
      aw_time <= $time;
    end
    if (w_valid && w_ready) begin
      w_beats.push_back(w);
    end
  end

  // ====================
  // helpers
  // ====================
  function automatic data_t initial_beat(input addr_t a);
    return {32'h0, a[31:3], 3'b000} ^ 64'h5a5a_0000_0000_1111;
  endfunction

  function automatic data_t expected_beat(input addr_t a);
    addr_t beat;
    beat = {a[31:3], 3'b000};
    if (ref_mem.exists(beat)) begin
      return ref_mem[beat];
    end
    return initial_beat(beat);
  endfunction

  function automatic addr_t line_addr(input tag_t t, input set_idx_t s);
    return {t, s, {offset_w{1'b0}}};
  endfunction

  // lines that crowd set 5
  function automatic addr_t crowded_line(input int i);
    return line_addr(tag_t'(23'h100 + i), 4'd5);
  endfunction

  task automatic check(input bit ok, input string what);
    assert (ok) else begin
      $display("CHECK FAILED at %0d ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $finish;
  endtask

  // one request and its response with random rsp_ready when stalling
  task automatic exchange(input req_op_e op, input addr_t addr, input source_t src,
                          input data_t wdata, input bit stall, output cpu_rsp_t got);
    int       waited;
    bit       done;
    bit       seen;
    cpu_rsp_t first;
    got = '0;
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= '{op: op, addr: addr, source: src, data: wdata};
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!req_ready && waited < accept_limit);
    if (!req_ready) begin
      abort_run("timeout: the cache did not accept a request");
    end else begin
      @(posedge clk);
      req_valid <= 1'b0;
      done   = 1'b0;
      seen   = 1'b0;
      first  = '0;
      waited = 0;
      while (!done && waited < rsp_limit) begin
        rsp_ready <= stall ? ($urandom_range(0, 3) == 0) : 1'b1;
        @(negedge clk);
        waited++;
        // no new request until the response is taken
        check(!req_ready, "req_ready high while a request is in flight");
        // an offered response holds until taken
        if (seen) begin
          check(rsp_valid && rsp == first, "response changed before it was accepted");
        end else if (rsp_valid) begin
          first = rsp;
          seen  = 1'b1;
        end
        if (rsp_valid && rsp_ready) begin
          got  = rsp;
          done = 1'b1;
        end
        @(posedge clk);
      end
      rsp_ready <= 1'b0;
      if (!done) begin
        abort_run("timeout: no response from the cache");
      end
    end
  endtask

  task automatic get_and_check(input addr_t addr, input source_t src, input bit stall);
    cpu_rsp_t got;
    data_t    want;
    want = expected_beat(addr);
    exchange(op_get, addr, src, '0, stall, got);
    check(got.op == op_ack_data, $sformatf("get 0x%08h answered without data", addr));
    check(got.source == src, $sformatf("get 0x%08h: source %0h, want %0h",
                                       addr, got.source, src));
    check(got.data == want, $sformatf("get 0x%08h: data 0x%016h, want 0x%016h",
                                      addr, got.data, want));
  endtask

  task automatic put_and_check(input addr_t addr, input source_t src, input data_t data,
                               input bit stall);
    cpu_rsp_t got;
    exchange(op_put, addr, src, data, stall, got);
    ref_mem[{addr[31:3], 3'b000}] = data;
    check(got.op == op_ack, $sformatf("put 0x%08h answered with data", addr));
    check(got.source == src, $sformatf("put 0x%08h: source %0h, want %0h",
                                       addr, got.source, src));
  endtask

  task automatic start_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors > errors_at_start) begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_at_start);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // ====================
  // directed tests
  // ====================
  task automatic after_reset_state();
    @(negedge clk);
    check(req_ready, "req_ready is low after reset");
    check(!rsp_valid && !ar_valid, "rsp or ar valid high after reset");
    check(!aw_valid && !w_valid, "aw or w valid high after reset");
    check(!r_ready && !b_ready, "r or b ready high after reset");
  endtask

  task automatic read_miss_then_hit();
    addr_t a;
    int    ar_before;
    a = line_addr(23'h10, 4'd1);
    ar_before = ar_count;
    get_and_check(a + 8, 4'h5, 1'b0);
    check(ar_count == ar_before + 1, "read miss did not issue exactly one ar");
    check(last_ar == a, $sformatf("ar address 0x%08h, want 0x%08h", last_ar, a));
    get_and_check(a + 24, 4'h6, 1'b0);
    check(ar_count == ar_before + 1, "read hit issued an ar");
  endtask

  task automatic write_hit_then_read();
    addr_t a;
    int    ar_before;
    int    aw_before;
    a = line_addr(23'h10, 4'd1);
    ar_before = ar_count;
    aw_before = aw_count;
    put_and_check(a + 16, 4'h7, 64'hdead_beef_0123_4567, 1'b0);
    get_and_check(a + 16, 4'h8, 1'b0);
    check(ar_count == ar_before && aw_count == aw_before, "write hit touched memory");
  endtask

  task automatic plru_writeback();
    int ar_before;
    int aw_before;
    aw_before = aw_count;
    // fill ways 0 to 3 with one dirty beat per line
    for (int i = 0; i < way_num; i++) begin
      put_and_check(crowded_line(i) + addr_t'(8 * i), source_t'(i),
                    64'h1111_2222_0000_0000 + data_t'(i), 1'b0);
    end
    check(aw_count == aw_before, "filling invalid ways wrote back a line");
    // touching A leaves the tree pointing at C
    get_and_check(crowded_line(0), 4'h9, 1'b0);
    w_beats.delete();
    ar_before = ar_count;
    aw_before = aw_count;
    put_and_check(crowded_line(4) + 8, 4'ha, 64'h0bad_cafe_5555_aaaa, 1'b0);
    check(aw_count == aw_before + 1, "eviction did not issue exactly one aw");
    check(last_aw == crowded_line(2), $sformatf("aw address 0x%08h, want 0x%08h",
                                                last_aw, crowded_line(2)));
    check(w_beats.size() == beat_num, $sformatf("%0d w beats", w_beats.size()));
    for (int i = 0; i < w_beats.size(); i++) begin
      check(w_beats[i].data == expected_beat(crowded_line(2) + addr_t'(8 * i)),
            $sformatf("w beat %0d: data 0x%016h", i, w_beats[i].data));
      check(w_beats[i].last == (i == beat_num - 1), $sformatf("w beat %0d: wrong last", i));
    end
    check(ar_count == ar_before + 1, "eviction did not issue exactly one ar");
    check(last_ar == crowded_line(4), $sformatf("ar address 0x%08h", last_ar));
    check(aw_time < ar_time, "ar came before the write-back aw");
  endtask

  task automatic evicted_data_survives();
    int ar_before;
    ar_before = ar_count;
    get_and_check(crowded_line(2) + 16, 4'hb, 1'b0);
    check(ar_count == ar_before + 1, "get to an evicted line did not miss");
  endtask

  task automatic back_pressure();
    addr_t a;
    int    ar_before;
    int    aw_before;
    a = line_addr(23'h2a, 4'd9);
    ar_before = ar_count;
    get_and_check(a + 8, 4'hc, 1'b1);
    check(ar_count == ar_before + 1, "stalled read miss did not issue one ar");
    aw_before = aw_count;
    get_and_check(a, 4'hd, 1'b1);
    put_and_check(a + 24, 4'he, 64'h7777_0000_feed_0001, 1'b1);
    get_and_check(a + 24, 4'hf, 1'b1);
    check(ar_count == ar_before + 1 && aw_count == aw_before, "stalled hits touched memory");
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    int waited;
    void'($urandom(32'hc481));
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    waited    = 0;
    while (!rst_n && waited < reset_limit) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) begin
      abort_run("reset was never released");
    end else begin
      start_test();
      after_reset_state();
      end_test("after_reset");
      start_test();
      read_miss_then_hit();
      end_test("read_miss_hit");
      start_test();
      write_hit_then_read();
      end_test("write_hit_read");
      start_test();
      plru_writeback();
      end_test("plru_writeback");
      start_test();
      evicted_data_survives();
      end_test("evicted_data");
      start_test();
      back_pressure();
      end_test("back_pressure");
      $display("summary: %0d tests run, %0d with errors, %0d failed checks",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
      $finish;
    end
  end

endmodule

// ==== tb_mem_model.sv ====
module tb_mem_model (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // read address and data
  input  logic                     ar_valid_i,
  output logic                     ar_ready_o,
  input  l2_cache_pkg::mem_addr_t  ar_i,
  output logic                     r_valid_o,
  input  logic                     r_ready_i,
  output l2_cache_pkg::mem_rdata_t r_o,
  // write address, data and response
  input  logic                     aw_valid_i,
  output logic                     aw_ready_o,
  input  l2_cache_pkg::mem_addr_t  aw_i,
  input  logic                     w_valid_i,
  output logic                     w_ready_o,
  input  l2_cache_pkg::mem_wdata_t w_i,
  output logic                     b_valid_o,
  input  logic                     b_ready_i,
  // burst counters
  output int                       ar_cnt_o,
  output int                       aw_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import l2_cache_pkg::*;

  // only beats that were written back are stored
  data_t mem [addr_t];
  logic  rd_busy;
  logic  wr_busy;
  addr_t rd_addr;
  addr_t wr_addr;
  int    rd_beat;
  int    wr_beat;

  // untouched beats follow from their address
  function automatic data_t read_beat(input addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {32'h0, a} ^ 64'h5a5a_0000_0000_1111;
  endfunction

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_o        = '0;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    b_valid_o  = 1'b0;
    ar_cnt_o   = 0;
    aw_cnt_o   = 0;
    rd_busy    = 1'b0;
    wr_busy    = 1'b0;
  end

  // ====================
  // read side
  // ====================
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      rd_busy    <= 1'b0;
      ar_cnt_o   <= 0;
    end else if (ar_valid_i && ar_ready_o) begin
      ar_ready_o <= 1'b0;
      rd_busy    <= 1'b1;
      rd_addr    <= ar_i.addr;
      rd_beat    <= 0;
      ar_cnt_o   <= ar_cnt_o + 1;
    end else if (!rd_busy) begin
      // random accept delay
      ar_ready_o <= ($urandom_range(0, 1) == 1);
    end else if (r_valid_o && r_ready_i) begin
      r_valid_o <= 1'b0;
      rd_beat   <= rd_beat + 1;
      if (rd_beat == beat_num - 1) begin
        rd_busy <= 1'b0;
      end
    end else if (!r_valid_o && ($urandom_range(0, 2) != 0)) begin
      // beats leave in order, last on the fourth
      r_valid_o <= 1'b1;
      r_o.data  <= read_beat(rd_addr + addr_t'(8 * rd_beat));
      r_o.last  <= (rd_beat == beat_num - 1);
    end
  end

  // ====================
  // write side
  // ====================
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      b_valid_o  <= 1'b0;
      wr_busy    <= 1'b0;
      aw_cnt_o   <= 0;
    end else if (aw_valid_i && aw_ready_o) begin
      aw_ready_o <= 1'b0;
      wr_busy    <= 1'b1;
      wr_addr    <= aw_i.addr;
      wr_beat    <= 0;
      aw_cnt_o   <= aw_cnt_o + 1;
    end else if (!wr_busy) begin
      aw_ready_o <= ($urandom_range(0, 1) == 1);
    end else if (b_valid_o) begin
      if (b_ready_i) begin
        b_valid_o <= 1'b0;
        wr_busy   <= 1'b0;
      end
    end else if (w_valid_i && w_ready_o) begin
      mem[wr_addr + addr_t'(8 * wr_beat)] = w_i.data;
      wr_beat   <= wr_beat + 1;
      w_ready_o <= 1'b0;
      // response right after the last beat
      b_valid_o <= w_i.last;
    end else begin
      w_ready_o <= ($urandom_range(0, 2) != 0);
    end
  end

endmodule
